//--- all.f
verilog/core_pkg.sv
verilog/stage_reg.sv
verilog/reg_file.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/writeback_unit.sv
verilog/alu_core.sv
tests/tb_alu_core.sv

//--- tests/tb_alu_core.sv
`timescale 1ns/1ps

module tb_alu_core;

  localparam int unsigned WB_DELAY = 3;
  localparam logic [31:0] SEED     = 32'h4acbb658;
  localparam int          TIMEOUT  = 1000;  // Cycles per wait

  logic              clk;
  logic              rst;
  logic              inst_valid_i;
  logic              inst_ready_o;
  logic [31:0]       inst_i;
  logic              commit_valid_o;
  logic              commit_ready_i;
  core_pkg::wb_pkt_t commit_o;

  core_pkg::wb_pkt_t exp_q [$];        // Expected commits in issue order
  core_pkg::wb_pkt_t exp_rec;
  logic [31:0]       ref_regs [0:31];  // Architectural state of the model
  logic [31:0]       rng;              // Stimulus stream
  logic [31:0]       rng_bp;           // Back-pressure stream
  logic              bp_en;
  int                errors;
  int                commits;
  int                issued;
  int                tests;
  int                err0;
  int                cmt0;

  alu_core #(.WB_DELAY (WB_DELAY)) alu_core_i (
    .clk (clk), .rst (rst),
    .inst_valid_i (inst_valid_i), .inst_ready_o (inst_ready_o), .inst_i (inst_i),
    .commit_valid_o (commit_valid_o), .commit_ready_i (commit_ready_i), .commit_o (commit_o)
  );

  always #4 clk = ~clk;  // 8 ns period

  // ################################################
  // Helpers
  // ################################################
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] r_inst(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_inst(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // Reference model applying one instruction in program order
  function automatic core_pkg::wb_pkt_t ref_exec(input logic [31:0] inst);
    logic [6:0]        opcode;
    logic [2:0]        f3;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       res;
    logic              legal;
    core_pkg::wb_pkt_t rec;
    opcode = inst[6:0];
    f3     = inst[14:12];
    a      = ref_regs[inst[19:15]];                // x0 is never written here
    b      = (opcode == 7'b0110011) ? ref_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
    legal  = 1'b1;
    res    = '0;
    if (opcode == 7'b0110011 && inst[31:25] == 7'h20 && f3 == 3'b000) begin
      res = a - b;
    end else if (opcode == 7'b0110011 && inst[31:25] == 7'h00) begin
      case (f3)
        3'b000:  res = a + b;
        3'b001:  res = a << b[4:0];
        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  res = a ^ b;
        3'b101:  res = a >> b[4:0];
        3'b110:  res = a | b;
        3'b111:  res = a & b;
        default: legal = 1'b0;  // sltu
      endcase
    end else if (opcode == 7'b0010011) begin
      case (f3)
        3'b000:  res = a + b;
        3'b100:  res = a ^ b;
        3'b110:  res = a | b;
        3'b111:  res = a & b;
        default: legal = 1'b0;  // slti, sltiu and shifts by immediate
      endcase
    end else begin
      legal = 1'b0;
    end
    rec.rd      = inst[11:7];
    rec.data    = res;                                   // Zero for illegal
    rec.wen     = legal && inst[11:7] != 5'd0;
    rec.illegal = !legal;
    if (rec.wen) ref_regs[inst[11:7]] = res;
    return rec;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic report_and_finish();
    $display("Tests %0d, issued %0d, commits %0d, errors %0d", tests, issued, commits, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    $display("Timeout, %s", what);
    errors++;
    report_and_finish();
  endtask

  task automatic start_test();
    err0 = errors;
    cmt0 = commits;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s done, %0d commits, %0d errors", tests, name, commits - cmt0,
             errors - err0);
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send(input logic [31:0] inst);
    int n;
    inst_i       = inst;
    inst_valid_i = 1'b1;
    n            = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!inst_ready_o && n < TIMEOUT);
    if (!inst_ready_o) begin
      abort_run("instruction port never became ready");
    end else begin
      exp_q.push_back(ref_exec(inst));  // Taken on this edge
      issued++;
      @(negedge clk);
    end
  endtask

  task automatic gap(input int cycles);
    inst_valid_i = 1'b0;
    repeat (cycles) @(negedge clk);
  endtask

  task automatic drain();
    int n;
    inst_valid_i = 1'b0;
    n            = 0;
    while (exp_q.size() != 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) abort_run("commits stopped before all instructions retired");
  endtask

  // No commit may show up once every instruction has retired
  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check("commit_valid_o", commit_valid_o, 1'b0);
    end
  endtask

  // Mostly legal ops on x0..x15 so hazards are frequent
  task automatic rand_inst(input logic with_illegal, output logic [31:0] inst);
    logic [31:0] r;
    logic [2:0]  f3;
    rng = xorshift(rng);
    r   = rng;
    rng = xorshift(rng);
    if (r[1:0] == 2'd3 && with_illegal) begin
      inst = rng;                                         // Raw word that is usually illegal
    end else if (r[1] == 1'b0) begin
      f3   = (r[4:2] == 3'b011) ? 3'b000 : r[4:2];
      inst = r_inst((r[5] && f3 == 3'b000) ? 7'h20 : 7'h00, f3,
                    {1'b0, r[9:6]}, {1'b0, r[13:10]}, {1'b0, r[17:14]});
    end else begin
      case (r[3:2])
        2'd0:    f3 = 3'b000;
        2'd1:    f3 = 3'b100;
        2'd2:    f3 = 3'b110;
        default: f3 = 3'b111;
      endcase
      inst = i_inst(f3, {1'b0, r[9:6]}, {1'b0, r[13:10]}, rng[11:0]);
    end
  endtask

  // ################################################
  // Commit compare and back-pressure
  // ################################################
  always @(posedge clk) begin
    if (rst && commit_valid_o && commit_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Commit seen with no instruction outstanding");
        errors++;
      end else begin
        exp_rec = exp_q.pop_front();
        check("commit_o.rd", commit_o.rd, exp_rec.rd);
        check("commit_o.data", commit_o.data, exp_rec.data);
        check("commit_o.wen", commit_o.wen, exp_rec.wen);
        check("commit_o.illegal", commit_o.illegal, exp_rec.illegal);
        commits++;
      end
    end
  end

  always @(negedge clk) begin
    rng_bp         = xorshift(rng_bp);
    commit_ready_i = bp_en ? rng_bp[0] : 1'b1;  // About half the cycles stalled
  end

  // ################################################
  // Stimulus
  // ################################################
  initial begin
    logic [31:0] inst;
    clk            = 1'b0;
    rst            = 1'b0;
    inst_valid_i   = 1'b0;
    inst_i         = '0;
    commit_ready_i = 1'b1;
    bp_en          = 1'b0;
    rng            = SEED;
    rng_bp         = ~SEED;
    errors         = 0;
    commits        = 0;
    issued         = 0;
    tests          = 0;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;

    start_test();  // Quiet after reset
    check("commit_valid_o", commit_valid_o, 1'b0);
    expect_quiet(20);
    end_test("reset and idle");

    start_test();
    send(i_inst(3'b000, 5'd1, 5'd0, 12'd1234));
    send(i_inst(3'b000, 5'd2, 5'd0, 12'hfb3));   // -77
    send(i_inst(3'b111, 5'd3, 5'd2, 12'h0f0));
    send(i_inst(3'b110, 5'd4, 5'd1, 12'h800));   // Most negative immediate
    send(i_inst(3'b100, 5'd5, 5'd2, 12'hfff));
    send(i_inst(3'b000, 5'd6, 5'd5, 12'h7ff));
    send(i_inst(3'b100, 5'd7, 5'd1, 12'h555));
    send(i_inst(3'b111, 5'd8, 5'd2, 12'hff0));
    drain();
    end_test("immediate ops");

    start_test();  // Each reads the previous rd
    send(r_inst(7'h00, 3'b000, 5'd10, 5'd1, 5'd2));
    send(r_inst(7'h20, 3'b000, 5'd11, 5'd10, 5'd1));
    send(r_inst(7'h00, 3'b100, 5'd12, 5'd11, 5'd10));
    send(r_inst(7'h00, 3'b001, 5'd13, 5'd12, 5'd1));
    send(r_inst(7'h00, 3'b101, 5'd14, 5'd13, 5'd3));
    send(r_inst(7'h00, 3'b010, 5'd15, 5'd14, 5'd2));
    send(r_inst(7'h00, 3'b110, 5'd16, 5'd15, 5'd13));
    send(r_inst(7'h00, 3'b111, 5'd17, 5'd16, 5'd12));
    send(r_inst(7'h00, 3'b000, 5'd17, 5'd17, 5'd17));
    drain();
    end_test("dependent chains");

    start_test();
    bp_en = 1'b1;
    repeat (30) begin
      rand_inst(1'b0, inst);
      send(inst);
    end
    drain();
    expect_quiet(20);  // A duplicate would surface here
    bp_en = 1'b0;
    end_test("back-pressure");

    start_test();
    send(i_inst(3'b000, 5'd5, 5'd0, 12'd321));
    send(r_inst(7'h01, 3'b000, 5'd5, 5'd1, 5'd2));  // Multiply encoding
    send(i_inst(3'b010, 5'd7, 5'd1, 12'd5));        // slti
    send(r_inst(7'h00, 3'b000, 5'd6, 5'd5, 5'd0));  // Must see 321
    send(32'hffff_ffff);
    send(r_inst(7'h00, 3'b000, 5'd8, 5'd7, 5'd7));
    drain();
    end_test("illegal encodings");

    start_test();
    bp_en = 1'b1;
    repeat (200) begin
      rand_inst(1'b1, inst);
      send(inst);
      rng = xorshift(rng);
      if (rng[1:0] != 2'd0) gap(rng[1:0]);  // Zero means back to back
    end
    drain();
    expect_quiet(20);
    bp_en = 1'b0;
    end_test("random stream");

    report_and_finish();
  end

endmodule

//--- verilog/alu_core.sv
`timescale 1ns/1ps

module alu_core #(
  parameter int unsigned WB_DELAY = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid_i,
  output logic              inst_ready_o,
  input  logic [31:0]       inst_i,
  output logic              commit_valid_o,
  input  logic              commit_ready_i,
  output core_pkg::wb_pkt_t commit_o
);

  // Register file ports
  logic [core_pkg::REG_ADDR_W-1:0] raddr_a;
  logic [core_pkg::REG_ADDR_W-1:0] raddr_b;
  logic [core_pkg::XLEN-1:0]       rdata_a;
  logic [core_pkg::XLEN-1:0]       rdata_b;
  logic                            rf_we;
  logic [core_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [core_pkg::XLEN-1:0]       rf_wdata;

  // Stage links
  logic               dec_valid;
  logic               dec_ready;
  core_pkg::dec_pkt_t dec_pkt;
  logic               ex_valid;
  logic               ex_ready;
  core_pkg::wb_pkt_t  ex_pkt;

  decode_unit decode_unit_i (
    .clk (clk), .rst (rst),
    .inst_valid_i (inst_valid_i), .inst_ready_o (inst_ready_o), .inst_i (inst_i),
    .raddr_a_o (raddr_a), .raddr_b_o (raddr_b), .rdata_a_i (rdata_a), .rdata_b_i (rdata_b),
    .wb_we_i (rf_we), .wb_waddr_i (rf_waddr),  // Scoreboard clear
    .dec_valid_o (dec_valid), .dec_ready_i (dec_ready), .dec_o (dec_pkt)
  );

  execute_unit execute_unit_i (
    .clk (clk), .rst (rst),
    .dec_valid_i (dec_valid), .dec_ready_o (dec_ready), .dec_i (dec_pkt),
    .ex_valid_o (ex_valid), .ex_ready_i (ex_ready), .ex_o (ex_pkt)
  );

  writeback_unit #(.WB_DELAY (WB_DELAY)) writeback_unit_i (
    .clk (clk), .rst (rst),
    .ex_valid_i (ex_valid), .ex_ready_o (ex_ready), .ex_i (ex_pkt),
    .rf_we_o (rf_we), .rf_waddr_o (rf_waddr), .rf_wdata_o (rf_wdata),
    .commit_valid_o (commit_valid_o), .commit_ready_i (commit_ready_i), .commit_o (commit_o)
  );

  reg_file reg_file_i (
    .clk (clk), .rst (rst),
    .raddr_a_i (raddr_a), .raddr_b_i (raddr_b), .rdata_a_o (rdata_a), .rdata_b_o (rdata_b),
    .we_i (rf_we), .waddr_i (rf_waddr), .wdata_i (rf_wdata)
  );

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

  // ################################################
  // Widths
  // ################################################
  localparam int XLEN       = 32;  // Data path width
  localparam int REG_ADDR_W = 5;   // 32 architectural registers

  // ################################################
  // Operations
  // ################################################
  typedef enum logic [3:0] {
    OP_ADD     = 4'd0,
    OP_SUB     = 4'd1,
    OP_AND     = 4'd2,
    OP_OR      = 4'd3,
    OP_XOR     = 4'd4,
    OP_SLL     = 4'd5,
    OP_SRL     = 4'd6,
    OP_SLT     = 4'd7,
    OP_ADDI    = 4'd8,
    OP_ANDI    = 4'd9,
    OP_ORI     = 4'd10,
    OP_XORI    = 4'd11,
    OP_ILLEGAL = 4'd15   // Anything decode does not know
  } op_e;

  // Decode to execute, 74 bits
  typedef struct packed {
    op_e                   op;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       opa;      // rs1 data
    logic [XLEN-1:0]       opb;      // rs2 data or sign extended immediate
    logic                  illegal;
  } dec_pkt_t;

  // Execute to write-back and commit record, 39 bits
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    logic                  wen;      // Low for x0 and for illegal
    logic                  illegal;
  } wb_pkt_t;

endpackage

//--- verilog/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            inst_valid_i,
  output logic                            inst_ready_o,
  input  logic [31:0]                     inst_i,
  output logic [core_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [core_pkg::REG_ADDR_W-1:0] raddr_b_o,
  input  logic [core_pkg::XLEN-1:0]       rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]       rdata_b_i,
  input  logic                            wb_we_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] wb_waddr_i,
  output logic                            dec_valid_o,
  input  logic                            dec_ready_i,
  output core_pkg::dec_pkt_t              dec_o
);

  localparam logic [6:0] OPC_REG = 7'b0110011;  // R-type ALU
  localparam logic [6:0] OPC_IMM = 7'b0010011;  // I-type ALU

  logic [6:0]                      opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [core_pkg::REG_ADDR_W-1:0] rd;
  logic [core_pkg::REG_ADDR_W-1:0] rs1;
  logic [core_pkg::REG_ADDR_W-1:0] rs2;
  logic [core_pkg::XLEN-1:0]       imm;
  logic                            is_reg;
  logic                            is_imm;
  core_pkg::op_e                   op;
  logic                            illegal;
  logic [31:0]                     pending;     // One bit per register awaiting write
  logic                            hazard;
  logic                            sreg_ready;
  core_pkg::dec_pkt_t              pkt;

  // ################################################
  // Field extraction and operation decode
  // ################################################
  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign funct7 = inst_i[31:25];
  assign imm    = {{20{inst_i[31]}}, inst_i[31:20]};
  assign is_reg = (opcode == OPC_REG);
  assign is_imm = (opcode == OPC_IMM);

  always_comb begin
    op = core_pkg::OP_ILLEGAL;
    if (is_reg && funct7 == 7'b0000000) begin
      case (funct3)
        3'b000:  op = core_pkg::OP_ADD;
        3'b001:  op = core_pkg::OP_SLL;
        3'b010:  op = core_pkg::OP_SLT;
        3'b100:  op = core_pkg::OP_XOR;
        3'b101:  op = core_pkg::OP_SRL;
        3'b110:  op = core_pkg::OP_OR;
        3'b111:  op = core_pkg::OP_AND;
        default: op = core_pkg::OP_ILLEGAL;  // sltu not supported
      endcase
    end else if (is_reg && funct7 == 7'b0100000 && funct3 == 3'b000) begin
      op = core_pkg::OP_SUB;
    end else if (is_imm) begin
      case (funct3)
        3'b000:  op = core_pkg::OP_ADDI;
        3'b100:  op = core_pkg::OP_XORI;
        3'b110:  op = core_pkg::OP_ORI;
        3'b111:  op = core_pkg::OP_ANDI;
        default: op = core_pkg::OP_ILLEGAL;
      endcase
    end
  end

  assign illegal = (op == core_pkg::OP_ILLEGAL);

  // Operand read
  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  assign pkt.op      = op;
  assign pkt.rd      = rd;
  assign pkt.opa     = rdata_a_i;
  assign pkt.opb     = is_reg ? rdata_b_i : imm;
  assign pkt.illegal = illegal;

  // ################################################
  // Scoreboard
  // ################################################
  // rs2 only matters for R-type, pending rd also stalls so one bit per register is enough
  assign hazard = !illegal && (pending[rs1] || pending[rd] || (is_reg && pending[rs2]));

  assign inst_ready_o = sreg_ready && !hazard;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pending <= '0;
    end else begin
      if (wb_we_i) pending[wb_waddr_i] <= 1'b0;  // Write lands this edge
      if (inst_valid_i && inst_ready_o && !illegal && rd != '0) begin
        pending[rd] <= 1'b1;
      end
    end
  end

  stage_reg #(
    .pkt_t (core_pkg::dec_pkt_t)
  ) dec_reg_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (inst_valid_i && !hazard),
    .in_ready_o  (sreg_ready),
    .in_pkt_i    (pkt),
    .out_valid_o (dec_valid_o),
    .out_ready_i (dec_ready_i),
    .out_pkt_o   (dec_o)
  );

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               dec_valid_i,
  output logic               dec_ready_o,
  input  core_pkg::dec_pkt_t dec_i,
  output logic               ex_valid_o,
  input  logic               ex_ready_i,
  output core_pkg::wb_pkt_t  ex_o
);

  logic [core_pkg::XLEN-1:0] opa;
  logic [core_pkg::XLEN-1:0] opb;
  logic [core_pkg::XLEN-1:0] result;
  logic                      lt;      // Signed less than
  core_pkg::wb_pkt_t         res;

  assign opa = dec_i.opa;
  assign opb = dec_i.opb;
  assign lt  = $signed(opa) < $signed(opb);

  // ################################################
  // ALU
  // ################################################
  always_comb begin
    case (dec_i.op)
      core_pkg::OP_ADD,
      core_pkg::OP_ADDI: result = opa + opb;
      core_pkg::OP_SUB:  result = opa - opb;
      core_pkg::OP_AND,
      core_pkg::OP_ANDI: result = opa & opb;
      core_pkg::OP_OR,
      core_pkg::OP_ORI:  result = opa | opb;
      core_pkg::OP_XOR,
      core_pkg::OP_XORI: result = opa ^ opb;
      core_pkg::OP_SLL:  result = opa << opb[4:0];  // Low 5 bits only
      core_pkg::OP_SRL:  result = opa >> opb[4:0];
      core_pkg::OP_SLT:  result = {{(core_pkg::XLEN-1){1'b0}}, lt};
      default:           result = '0;               // Illegal carries no data
    endcase
  end

  assign res.rd      = dec_i.rd;
  assign res.data    = result;
  assign res.wen     = !dec_i.illegal && dec_i.rd != '0;
  assign res.illegal = dec_i.illegal;

  stage_reg #(
    .pkt_t (core_pkg::wb_pkt_t)
  ) ex_reg_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (dec_valid_i),
    .in_ready_o  (dec_ready_o),
    .in_pkt_i    (res),
    .out_valid_o (ex_valid_o),
    .out_ready_i (ex_ready_i),
    .out_pkt_o   (ex_o)
  );

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                            we_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]       wdata_i
);

  logic [core_pkg::XLEN-1:0] regs [0:31];

  // Asynchronous reads, x0 forced to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

  // ################################################
  // Write port
  // ################################################
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;  // x0 never takes a write
    end
  end

  // Execute clears wen for rd 0, so write-back never targets x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst)
    we_i |-> waddr_i != '0);

endmodule

//--- verilog/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
  parameter type pkt_t = logic [31:0]
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  pkt_t in_pkt_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output pkt_t out_pkt_o
);

  logic full;     // One entry held
  pkt_t pkt_q;

  assign in_ready_o  = !full || out_ready_i;  // Drain and refill in one cycle
  assign out_valid_o = full;
  assign out_pkt_o   = pkt_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      full <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      full <= 1'b1;
    end else if (out_ready_i) begin
      full <= 1'b0;  // Consumer took the last entry
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) pkt_q <= in_pkt_i;
  end

  // Producer side of the handshake holds until taken
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pkt_o));

endmodule

//--- verilog/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit #(
  parameter int unsigned WB_DELAY = 3   // 0 to 255
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            ex_valid_i,
  output logic                            ex_ready_o,
  input  core_pkg::wb_pkt_t               ex_i,
  output logic                            rf_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                            commit_valid_o,
  input  logic                            commit_ready_i,
  output core_pkg::wb_pkt_t               commit_o
);

  localparam logic [7:0] DELAY_MAX = WB_DELAY[7:0];

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    WBACK = 2'b01,
    WAIT  = 2'b10
  } state_e;

  state_e            state;
  state_e            state_nxt;
  logic [7:0]        cnt;       // Cycles spent in WBACK
  logic              accept;
  core_pkg::wb_pkt_t pkt_q;     // Record held for commit

  assign ex_ready_o     = (state == IDLE);
  assign accept         = ex_valid_i && ex_ready_o;
  assign commit_valid_o = (state == WAIT);
  assign commit_o       = pkt_q;

  // Register write goes out in the accepting cycle
  assign rf_we_o    = accept && ex_i.wen;
  assign rf_waddr_o = ex_i.rd;
  assign rf_wdata_o = ex_i.data;

  // ################################################
  // State machine
  // ################################################
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (ex_valid_i) state_nxt = WBACK;
      WBACK:   if (cnt == DELAY_MAX) state_nxt = WAIT;  // WB_DELAY+1 cycles here
      WAIT:    if (commit_ready_i) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (state == WBACK && state_nxt == WBACK) cnt <= cnt + 8'd1;
      else cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) pkt_q <= ex_i;
  end

  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst)
    cnt <= DELAY_MAX);

endmodule
